// ==== src/axi_lite_cdc_pkg.sv ====
/* AXI4-Lite widths and channel payloads. There are no IDs, bursts or user bits */
package axi_lite_cdc_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [2:0]           prot_t;
  typedef logic [1:0]           resp_t;

  // Response codes
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

endpackage

// ==== src/cdc_fifo_gray_src.sv ====
/* Write half of a gray-pointer CDC FIFO of 2**LogDepth entries, LogDepth >= 1.
   The async_* ports cross into the read clock domain */
`timescale 1ns/1ps

module cdc_fifo_gray_src #(
  parameter type         payload_t = logic,
  parameter int unsigned LogDepth  = 1
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  payload_t                   data_i,
  output logic                       ready_o,
  output payload_t [2**LogDepth-1:0] async_data_o,
  output logic     [LogDepth:0]      async_wptr_o,
  input  logic     [LogDepth:0]      async_rptr_i
);

  // In gray code a full FIFO differs from the read pointer in the two top bits only
  localparam logic [LogDepth:0] FullMask = (LogDepth + 1)'(3) << (LogDepth - 1);

  payload_t [2**LogDepth-1:0] mem_q;
  logic [LogDepth:0] wptr_bin_q, wptr_bin_d;
  logic [LogDepth:0] wptr_gray_q;
  logic [LogDepth:0] rptr_sync_q1, rptr_sync_q2;
  logic              push;

  assign ready_o    = (wptr_gray_q != (rptr_sync_q2 ^ FullMask));
  assign push       = valid_i & ready_o;
  assign wptr_bin_d = wptr_bin_q + (LogDepth + 1)'(1);

  // Entry is written on the same edge that publishes the new pointer
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_bin_q[LogDepth-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= wptr_bin_d ^ (wptr_bin_d >> 1);
    end
  end

  // Two-flop synchronizer for the remote read pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_sync_q1 <= '0;
      rptr_sync_q2 <= '0;
    end else begin
      rptr_sync_q1 <= async_rptr_i;
      rptr_sync_q2 <= rptr_sync_q1;
    end
  end

  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_gray_q;

endmodule

// ==== src/cdc_fifo_gray_dst.sv ====
/* Read half of a gray-pointer CDC FIFO of 2**LogDepth entries, LogDepth >= 1.
   data_o is read straight from the write half's storage */
`timescale 1ns/1ps

module cdc_fifo_gray_dst #(
  parameter type         payload_t = logic,
  parameter int unsigned LogDepth  = 1
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  output logic                       valid_o,
  output payload_t                   data_o,
  input  logic                       ready_i,
  input  payload_t [2**LogDepth-1:0] async_data_i,
  input  logic     [LogDepth:0]      async_wptr_i,
  output logic     [LogDepth:0]      async_rptr_o
);

  logic [LogDepth:0] rptr_bin_q, rptr_bin_d;
  logic [LogDepth:0] rptr_gray_q;
  logic [LogDepth:0] wptr_sync_q1, wptr_sync_q2;
  logic              pop;

  // Empty while both gray pointers match
  assign valid_o    = (rptr_gray_q != wptr_sync_q2);
  assign data_o     = async_data_i[rptr_bin_q[LogDepth-1:0]];
  assign pop        = valid_o & ready_i;
  assign rptr_bin_d = rptr_bin_q + (LogDepth + 1)'(1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (pop) begin
      rptr_bin_q  <= rptr_bin_d;
      rptr_gray_q <= rptr_bin_d ^ (rptr_bin_d >> 1);
    end
  end

  // Two-flop synchronizer for the remote write pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_sync_q1 <= '0;
      wptr_sync_q2 <= '0;
    end else begin
      wptr_sync_q1 <= async_wptr_i;
      wptr_sync_q2 <= wptr_sync_q1;
    end
  end

  assign async_rptr_o = rptr_gray_q;

endmodule

// ==== src/axi_lite_cdc_src.sv ====
/* Source side of the AXI4-Lite crossing, all logic on src_clk_i.
   Requests go into FIFO write halves, responses come out of FIFO read halves */
`timescale 1ns/1ps

module axi_lite_cdc_src #(
  parameter int unsigned LogDepth = 1
) (
  input  logic                                          src_clk_i,
  input  logic                                          reset_i,
  input  logic                                          aw_valid_i,
  input  axi_lite_cdc_pkg::addr_t                       aw_addr_i,
  input  axi_lite_cdc_pkg::prot_t                       aw_prot_i,
  output logic                                          aw_ready_o,
  input  logic                                          w_valid_i,
  input  axi_lite_cdc_pkg::data_t                       w_data_i,
  input  axi_lite_cdc_pkg::strb_t                       w_strb_i,
  output logic                                          w_ready_o,
  output logic                                          b_valid_o,
  output axi_lite_cdc_pkg::resp_t                       b_resp_o,
  input  logic                                          b_ready_i,
  input  logic                                          ar_valid_i,
  input  axi_lite_cdc_pkg::addr_t                       ar_addr_i,
  input  axi_lite_cdc_pkg::prot_t                       ar_prot_i,
  output logic                                          ar_ready_o,
  output logic                                          r_valid_o,
  output axi_lite_cdc_pkg::data_t                       r_data_o,
  output axi_lite_cdc_pkg::resp_t                       r_resp_o,
  input  logic                                          r_ready_i,
  output axi_lite_cdc_pkg::aw_chan_t [2**LogDepth-1:0]  async_aw_data_o,
  output axi_lite_cdc_pkg::w_chan_t  [2**LogDepth-1:0]  async_w_data_o,
  input  axi_lite_cdc_pkg::b_chan_t  [2**LogDepth-1:0]  async_b_data_i,
  output axi_lite_cdc_pkg::ar_chan_t [2**LogDepth-1:0]  async_ar_data_o,
  input  axi_lite_cdc_pkg::r_chan_t  [2**LogDepth-1:0]  async_r_data_i,
  output logic [LogDepth:0] async_aw_wptr_o, async_w_wptr_o, async_ar_wptr_o,
  input  logic [LogDepth:0] async_aw_rptr_i, async_w_rptr_i, async_ar_rptr_i,
  input  logic [LogDepth:0] async_b_wptr_i, async_r_wptr_i,
  output logic [LogDepth:0] async_b_rptr_o, async_r_rptr_o
);

  axi_lite_cdc_pkg::aw_chan_t aw_chan;
  axi_lite_cdc_pkg::w_chan_t  w_chan;
  axi_lite_cdc_pkg::b_chan_t  b_chan;
  axi_lite_cdc_pkg::ar_chan_t ar_chan;
  axi_lite_cdc_pkg::r_chan_t  r_chan;

  // Pack requests, unpack responses
  assign aw_chan  = '{addr: aw_addr_i, prot: aw_prot_i};
  assign w_chan   = '{data: w_data_i, strb: w_strb_i};
  assign ar_chan  = '{addr: ar_addr_i, prot: ar_prot_i};
  assign b_resp_o = b_chan.resp;
  assign r_data_o = r_chan.data;
  assign r_resp_o = r_chan.resp;

  cdc_fifo_gray_src #(
    .payload_t(axi_lite_cdc_pkg::aw_chan_t), .LogDepth(LogDepth)
  ) i_aw_fifo (
    .clk_i(src_clk_i), .reset_i, .valid_i(aw_valid_i), .data_i(aw_chan), .ready_o(aw_ready_o),
    .async_data_o(async_aw_data_o), .async_wptr_o(async_aw_wptr_o), .async_rptr_i(async_aw_rptr_i)
  );

  cdc_fifo_gray_src #(
    .payload_t(axi_lite_cdc_pkg::w_chan_t), .LogDepth(LogDepth)
  ) i_w_fifo (
    .clk_i(src_clk_i), .reset_i, .valid_i(w_valid_i), .data_i(w_chan), .ready_o(w_ready_o),
    .async_data_o(async_w_data_o), .async_wptr_o(async_w_wptr_o), .async_rptr_i(async_w_rptr_i)
  );

  cdc_fifo_gray_src #(
    .payload_t(axi_lite_cdc_pkg::ar_chan_t), .LogDepth(LogDepth)
  ) i_ar_fifo (
    .clk_i(src_clk_i), .reset_i, .valid_i(ar_valid_i), .data_i(ar_chan), .ready_o(ar_ready_o),
    .async_data_o(async_ar_data_o), .async_wptr_o(async_ar_wptr_o), .async_rptr_i(async_ar_rptr_i)
  );

  cdc_fifo_gray_dst #(
    .payload_t(axi_lite_cdc_pkg::b_chan_t), .LogDepth(LogDepth)
  ) i_b_fifo (
    .clk_i(src_clk_i), .reset_i, .valid_o(b_valid_o), .data_o(b_chan), .ready_i(b_ready_i),
    .async_data_i(async_b_data_i), .async_wptr_i(async_b_wptr_i), .async_rptr_o(async_b_rptr_o)
  );

  cdc_fifo_gray_dst #(
    .payload_t(axi_lite_cdc_pkg::r_chan_t), .LogDepth(LogDepth)
  ) i_r_fifo (
    .clk_i(src_clk_i), .reset_i, .valid_o(r_valid_o), .data_o(r_chan), .ready_i(r_ready_i),
    .async_data_i(async_r_data_i), .async_wptr_i(async_r_wptr_i), .async_rptr_o(async_r_rptr_o)
  );

endmodule

// ==== src/axi_lite_cdc_dst.sv ====
/* Destination side of the AXI4-Lite crossing, all logic on dst_clk_i.
   Requests come out of FIFO read halves, responses go into FIFO write halves */
`timescale 1ns/1ps

module axi_lite_cdc_dst #(
  parameter int unsigned LogDepth = 1
) (
  input  logic                                          dst_clk_i,
  input  logic                                          reset_i,
  output logic                                          aw_valid_o,
  output axi_lite_cdc_pkg::addr_t                       aw_addr_o,
  output axi_lite_cdc_pkg::prot_t                       aw_prot_o,
  input  logic                                          aw_ready_i,
  output logic                                          w_valid_o,
  output axi_lite_cdc_pkg::data_t                       w_data_o,
  output axi_lite_cdc_pkg::strb_t                       w_strb_o,
  input  logic                                          w_ready_i,
  input  logic                                          b_valid_i,
  input  axi_lite_cdc_pkg::resp_t                       b_resp_i,
  output logic                                          b_ready_o,
  output logic                                          ar_valid_o,
  output axi_lite_cdc_pkg::addr_t                       ar_addr_o,
  output axi_lite_cdc_pkg::prot_t                       ar_prot_o,
  input  logic                                          ar_ready_i,
  input  logic                                          r_valid_i,
  input  axi_lite_cdc_pkg::data_t                       r_data_i,
  input  axi_lite_cdc_pkg::resp_t                       r_resp_i,
  output logic                                          r_ready_o,
  input  axi_lite_cdc_pkg::aw_chan_t [2**LogDepth-1:0]  async_aw_data_i,
  input  axi_lite_cdc_pkg::w_chan_t  [2**LogDepth-1:0]  async_w_data_i,
  output axi_lite_cdc_pkg::b_chan_t  [2**LogDepth-1:0]  async_b_data_o,
  input  axi_lite_cdc_pkg::ar_chan_t [2**LogDepth-1:0]  async_ar_data_i,
  output axi_lite_cdc_pkg::r_chan_t  [2**LogDepth-1:0]  async_r_data_o,
  input  logic [LogDepth:0] async_aw_wptr_i, async_w_wptr_i, async_ar_wptr_i,
  output logic [LogDepth:0] async_aw_rptr_o, async_w_rptr_o, async_ar_rptr_o,
  output logic [LogDepth:0] async_b_wptr_o, async_r_wptr_o,
  input  logic [LogDepth:0] async_b_rptr_i, async_r_rptr_i
);

  axi_lite_cdc_pkg::aw_chan_t aw_chan;
  axi_lite_cdc_pkg::w_chan_t  w_chan;
  axi_lite_cdc_pkg::b_chan_t  b_chan;
  axi_lite_cdc_pkg::ar_chan_t ar_chan;
  axi_lite_cdc_pkg::r_chan_t  r_chan;

  // Unpack requests toward the slave, pack its responses
  assign aw_addr_o = aw_chan.addr;
  assign aw_prot_o = aw_chan.prot;
  assign w_data_o  = w_chan.data;
  assign w_strb_o  = w_chan.strb;
  assign ar_addr_o = ar_chan.addr;
  assign ar_prot_o = ar_chan.prot;
  assign b_chan    = '{resp: b_resp_i};
  assign r_chan    = '{data: r_data_i, resp: r_resp_i};

  cdc_fifo_gray_dst #(
    .payload_t(axi_lite_cdc_pkg::aw_chan_t), .LogDepth(LogDepth)
  ) i_aw_fifo (
    .clk_i(dst_clk_i), .reset_i, .valid_o(aw_valid_o), .data_o(aw_chan), .ready_i(aw_ready_i),
    .async_data_i(async_aw_data_i), .async_wptr_i(async_aw_wptr_i), .async_rptr_o(async_aw_rptr_o)
  );

  cdc_fifo_gray_dst #(
    .payload_t(axi_lite_cdc_pkg::w_chan_t), .LogDepth(LogDepth)
  ) i_w_fifo (
    .clk_i(dst_clk_i), .reset_i, .valid_o(w_valid_o), .data_o(w_chan), .ready_i(w_ready_i),
    .async_data_i(async_w_data_i), .async_wptr_i(async_w_wptr_i), .async_rptr_o(async_w_rptr_o)
  );

  cdc_fifo_gray_dst #(
    .payload_t(axi_lite_cdc_pkg::ar_chan_t), .LogDepth(LogDepth)
  ) i_ar_fifo (
    .clk_i(dst_clk_i), .reset_i, .valid_o(ar_valid_o), .data_o(ar_chan), .ready_i(ar_ready_i),
    .async_data_i(async_ar_data_i), .async_wptr_i(async_ar_wptr_i), .async_rptr_o(async_ar_rptr_o)
  );

  cdc_fifo_gray_src #(
    .payload_t(axi_lite_cdc_pkg::b_chan_t), .LogDepth(LogDepth)
  ) i_b_fifo (
    .clk_i(dst_clk_i), .reset_i, .valid_i(b_valid_i), .data_i(b_chan), .ready_o(b_ready_o),
    .async_data_o(async_b_data_o), .async_wptr_o(async_b_wptr_o), .async_rptr_i(async_b_rptr_i)
  );

  cdc_fifo_gray_src #(
    .payload_t(axi_lite_cdc_pkg::r_chan_t), .LogDepth(LogDepth)
  ) i_r_fifo (
    .clk_i(dst_clk_i), .reset_i, .valid_i(r_valid_i), .data_i(r_chan), .ready_o(r_ready_o),
    .async_data_o(async_r_data_o), .async_wptr_o(async_r_wptr_o), .async_rptr_i(async_r_rptr_i)
  );

endmodule

// ==== src/axi_lite_cdc.sv ====
/* AXI4-Lite crossing from src_clk_i to dst_clk_i with no fixed latency.
   reset_i must cover at least one edge of each clock */
`timescale 1ns/1ps

module axi_lite_cdc #(
  parameter int unsigned LogDepth = 1
) (
  input  logic                    src_clk_i,
  input  logic                    dst_clk_i,
  input  logic                    reset_i,
  // Source side, driven by the master
  input  logic                    src_aw_valid_i,
  input  axi_lite_cdc_pkg::addr_t src_aw_addr_i,
  input  axi_lite_cdc_pkg::prot_t src_aw_prot_i,
  output logic                    src_aw_ready_o,
  input  logic                    src_w_valid_i,
  input  axi_lite_cdc_pkg::data_t src_w_data_i,
  input  axi_lite_cdc_pkg::strb_t src_w_strb_i,
  output logic                    src_w_ready_o,
  output logic                    src_b_valid_o,
  output axi_lite_cdc_pkg::resp_t src_b_resp_o,
  input  logic                    src_b_ready_i,
  input  logic                    src_ar_valid_i,
  input  axi_lite_cdc_pkg::addr_t src_ar_addr_i,
  input  axi_lite_cdc_pkg::prot_t src_ar_prot_i,
  output logic                    src_ar_ready_o,
  output logic                    src_r_valid_o,
  output axi_lite_cdc_pkg::data_t src_r_data_o,
  output axi_lite_cdc_pkg::resp_t src_r_resp_o,
  input  logic                    src_r_ready_i,
  // Destination side, toward the slave
  output logic                    dst_aw_valid_o,
  output axi_lite_cdc_pkg::addr_t dst_aw_addr_o,
  output axi_lite_cdc_pkg::prot_t dst_aw_prot_o,
  input  logic                    dst_aw_ready_i,
  output logic                    dst_w_valid_o,
  output axi_lite_cdc_pkg::data_t dst_w_data_o,
  output axi_lite_cdc_pkg::strb_t dst_w_strb_o,
  input  logic                    dst_w_ready_i,
  input  logic                    dst_b_valid_i,
  input  axi_lite_cdc_pkg::resp_t dst_b_resp_i,
  output logic                    dst_b_ready_o,
  output logic                    dst_ar_valid_o,
  output axi_lite_cdc_pkg::addr_t dst_ar_addr_o,
  output axi_lite_cdc_pkg::prot_t dst_ar_prot_o,
  input  logic                    dst_ar_ready_i,
  input  logic                    dst_r_valid_i,
  input  axi_lite_cdc_pkg::data_t dst_r_data_i,
  input  axi_lite_cdc_pkg::resp_t dst_r_resp_i,
  output logic                    dst_r_ready_o
);

  // Signals that cross between the two clock domains
  axi_lite_cdc_pkg::aw_chan_t [2**LogDepth-1:0] aw_data;
  axi_lite_cdc_pkg::w_chan_t  [2**LogDepth-1:0] w_data;
  axi_lite_cdc_pkg::b_chan_t  [2**LogDepth-1:0] b_data;
  axi_lite_cdc_pkg::ar_chan_t [2**LogDepth-1:0] ar_data;
  axi_lite_cdc_pkg::r_chan_t  [2**LogDepth-1:0] r_data;
  logic [LogDepth:0] aw_wptr, aw_rptr, w_wptr, w_rptr, ar_wptr, ar_rptr;
  logic [LogDepth:0] b_wptr, b_rptr, r_wptr, r_rptr;

  axi_lite_cdc_src #(
    .LogDepth(LogDepth)
  ) i_axi_lite_cdc_src (
    .src_clk_i, .reset_i,
    .aw_valid_i(src_aw_valid_i), .aw_addr_i(src_aw_addr_i), .aw_prot_i(src_aw_prot_i),
    .aw_ready_o(src_aw_ready_o),
    .w_valid_i(src_w_valid_i), .w_data_i(src_w_data_i), .w_strb_i(src_w_strb_i),
    .w_ready_o(src_w_ready_o),
    .b_valid_o(src_b_valid_o), .b_resp_o(src_b_resp_o), .b_ready_i(src_b_ready_i),
    .ar_valid_i(src_ar_valid_i), .ar_addr_i(src_ar_addr_i), .ar_prot_i(src_ar_prot_i),
    .ar_ready_o(src_ar_ready_o),
    .r_valid_o(src_r_valid_o), .r_data_o(src_r_data_o), .r_resp_o(src_r_resp_o),
    .r_ready_i(src_r_ready_i),
    .async_aw_data_o(aw_data), .async_aw_wptr_o(aw_wptr), .async_aw_rptr_i(aw_rptr),
    .async_w_data_o(w_data), .async_w_wptr_o(w_wptr), .async_w_rptr_i(w_rptr),
    .async_b_data_i(b_data), .async_b_wptr_i(b_wptr), .async_b_rptr_o(b_rptr),
    .async_ar_data_o(ar_data), .async_ar_wptr_o(ar_wptr), .async_ar_rptr_i(ar_rptr),
    .async_r_data_i(r_data), .async_r_wptr_i(r_wptr), .async_r_rptr_o(r_rptr)
  );

  axi_lite_cdc_dst #(
    .LogDepth(LogDepth)
  ) i_axi_lite_cdc_dst (
    .dst_clk_i, .reset_i,
    .aw_valid_o(dst_aw_valid_o), .aw_addr_o(dst_aw_addr_o), .aw_prot_o(dst_aw_prot_o),
    .aw_ready_i(dst_aw_ready_i),
    .w_valid_o(dst_w_valid_o), .w_data_o(dst_w_data_o), .w_strb_o(dst_w_strb_o),
    .w_ready_i(dst_w_ready_i),
    .b_valid_i(dst_b_valid_i), .b_resp_i(dst_b_resp_i), .b_ready_o(dst_b_ready_o),
    .ar_valid_o(dst_ar_valid_o), .ar_addr_o(dst_ar_addr_o), .ar_prot_o(dst_ar_prot_o),
    .ar_ready_i(dst_ar_ready_i),
    .r_valid_i(dst_r_valid_i), .r_data_i(dst_r_data_i), .r_resp_i(dst_r_resp_i),
    .r_ready_o(dst_r_ready_o),
    .async_aw_data_i(aw_data), .async_aw_wptr_i(aw_wptr), .async_aw_rptr_o(aw_rptr),
    .async_w_data_i(w_data), .async_w_wptr_i(w_wptr), .async_w_rptr_o(w_rptr),
    .async_b_data_o(b_data), .async_b_wptr_o(b_wptr), .async_b_rptr_i(b_rptr),
    .async_ar_data_i(ar_data), .async_ar_wptr_i(ar_wptr), .async_ar_rptr_o(ar_rptr),
    .async_r_data_o(r_data), .async_r_wptr_o(r_wptr), .async_r_rptr_i(r_rptr)
  );

endmodule

// ==== tests/tb_axi_lite_cdc.sv ====
/* Random AXI4-Lite master and 16-word slave model around the CDC, LogDepth 1.
   Writes and reads run in separate phases so read data is fully defined */
`timescale 1ns/1ps

module tb_axi_lite_cdc;

  localparam int unsigned LogDepth = 1;
  localparam int unsigned MaxCycles = 20000;

  logic src_clk_i = 1'b0, dst_clk_i = 1'b0, reset_i;
  logic src_aw_valid_i, src_aw_ready_o, src_w_valid_i, src_w_ready_o;
  logic src_b_valid_o, src_ar_valid_i, src_ar_ready_o, src_r_valid_o;
  logic src_b_ready_i = 1'b0, src_r_ready_i = 1'b0;
  logic [31:0] src_aw_addr_i, src_w_data_i, src_ar_addr_i, src_r_data_o;
  logic [2:0] src_aw_prot_i, src_ar_prot_i;
  logic [3:0] src_w_strb_i;
  logic [1:0] src_b_resp_o, src_r_resp_o;
  logic dst_aw_valid_o, dst_w_valid_o, dst_b_ready_o, dst_ar_valid_o, dst_r_ready_o;
  logic dst_aw_ready_i = 1'b0, dst_w_ready_i = 1'b0, dst_ar_ready_i = 1'b0;
  logic dst_b_valid_i = 1'b0, dst_r_valid_i = 1'b0;
  logic [31:0] dst_aw_addr_o, dst_w_data_o, dst_ar_addr_o;
  logic [31:0] dst_r_data_i = '0;
  logic [2:0] dst_aw_prot_o, dst_ar_prot_o;
  logic [3:0] dst_w_strb_o;
  logic [1:0] dst_b_resp_i = '0, dst_r_resp_i = '0;

  // Reference queues filled by the master as it issues
  logic [34:0] exp_aw[$];
  logic [35:0] exp_w[$];
  logic [1:0]  exp_b[$];
  logic [34:0] exp_ar[$];
  logic [33:0] exp_r[$];
  logic [31:0] ref_mem[16], slave_mem[16];
  logic [31:0] slv_aw[$], slv_ar[$];
  logic [35:0] slv_w[$];

  int cycles = 0, ready_pct = 100, pass_cnt = 0, fail_cnt = 0;
  int b_count = 0, r_count = 0;
  int err_idle = 0, err_wt = 0, err_wr = 0, err_rb = 0, err_bp = 0, err_full = 0;
  bit bp_phase = 1'b0, hold_aw = 1'b0, b_fire = 1'b0, r_fire = 1'b0;

  axi_lite_cdc #(.LogDepth(LogDepth)) dut_i (.*);

  initial forever #10 src_clk_i = ~src_clk_i;
  initial forever #15 dst_clk_i = ~dst_clk_i;

  always @(posedge src_clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run stopped after %0d source cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic bit chance();
    return ($urandom % 100) < ready_pct;
  endfunction

  function automatic int mismatch(string name, logic [35:0] exp, logic [35:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      return 1;
    end
    return 0;
  endfunction

  // Response the slave must give for an address
  function automatic logic [1:0] rule_resp(logic [31:0] addr);
    return addr[6] ? 2'b10 : 2'b00;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] data, logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  // Master side response collectors decide the handshake after the falling edge
  always @(negedge src_clk_i) begin
    src_b_ready_i = chance();
    src_r_ready_i = chance();
    #1;
    if (src_b_valid_o && src_b_ready_i) begin
      b_count++;
      if (exp_b.size() == 0) begin
        $display("Unexpected B response with no write pending");
        err_bp++;
      end else if (bp_phase) begin
        err_bp += mismatch("back_pressure", 36'(exp_b.pop_front()), 36'(src_b_resp_o));
      end else begin
        err_wr += mismatch("write_resp", 36'(exp_b.pop_front()), 36'(src_b_resp_o));
      end
    end
    if (src_r_valid_o && src_r_ready_i) begin
      r_count++;
      if (exp_r.size() == 0) begin
        $display("Unexpected R response with no read pending");
        err_bp++;
      end else if (bp_phase) begin
        err_bp += mismatch("back_pressure", 36'(exp_r.pop_front()),
                           36'({src_r_data_o, src_r_resp_o}));
      end else begin
        err_rb += mismatch("read_back", 36'(exp_r.pop_front()),
                           36'({src_r_data_o, src_r_resp_o}));
      end
    end
  end

  // Slave model on the destination clock
  always @(negedge dst_clk_i) begin
    logic [31:0] a;
    logic [35:0] wd;
    dst_aw_ready_i = !hold_aw && chance();
    dst_w_ready_i  = chance();
    dst_ar_ready_i = chance();
    if (b_fire) dst_b_valid_i = 1'b0;
    if (r_fire) dst_r_valid_i = 1'b0;
    if (!dst_b_valid_i && slv_aw.size() > 0 && slv_w.size() > 0) begin
      a  = slv_aw.pop_front();
      wd = slv_w.pop_front();
      if (!a[6]) slave_mem[a[5:2]] = merge(slave_mem[a[5:2]], wd[35:4], wd[3:0]);
      dst_b_resp_i  = rule_resp(a);
      dst_b_valid_i = 1'b1;
    end
    if (!dst_r_valid_i && slv_ar.size() > 0) begin
      a = slv_ar.pop_front();
      dst_r_data_i  = slave_mem[a[5:2]];
      dst_r_resp_i  = rule_resp(a);
      dst_r_valid_i = 1'b1;
    end
    #1;
    b_fire = dst_b_valid_i && dst_b_ready_o;
    r_fire = dst_r_valid_i && dst_r_ready_o;
    if (dst_aw_valid_o && dst_aw_ready_i) begin
      slv_aw.push_back(dst_aw_addr_o);
      if (exp_aw.size() == 0) begin
        $display("Unexpected AW transfer at the destination");
        err_bp++;
      end else if (bp_phase) begin
        err_bp += mismatch("back_pressure", 36'(exp_aw.pop_front()),
                           36'({dst_aw_addr_o, dst_aw_prot_o}));
      end else begin
        err_wt += mismatch("write_through", 36'(exp_aw.pop_front()),
                           36'({dst_aw_addr_o, dst_aw_prot_o}));
      end
    end
    if (dst_w_valid_o && dst_w_ready_i) begin
      slv_w.push_back({dst_w_data_o, dst_w_strb_o});
      if (exp_w.size() == 0) begin
        $display("Unexpected W transfer at the destination");
        err_bp++;
      end else if (bp_phase) begin
        err_bp += mismatch("back_pressure", exp_w.pop_front(), {dst_w_data_o, dst_w_strb_o});
      end else begin
        err_wt += mismatch("write_through", exp_w.pop_front(), {dst_w_data_o, dst_w_strb_o});
      end
    end
    if (dst_ar_valid_o && dst_ar_ready_i) begin
      slv_ar.push_back(dst_ar_addr_o);
      if (exp_ar.size() == 0) begin
        $display("Unexpected AR transfer at the destination");
        err_bp++;
      end else if (bp_phase) begin
        err_bp += mismatch("back_pressure", 36'(exp_ar.pop_front()),
                           36'({dst_ar_addr_o, dst_ar_prot_o}));
      end else begin
        err_rb += mismatch("read_back", 36'(exp_ar.pop_front()),
                           36'({dst_ar_addr_o, dst_ar_prot_o}));
      end
    end
  end

  task automatic issue_write();
    logic [31:0] addr, data;
    logic [3:0] strb;
    logic [2:0] prot;
    bit aw_done, w_done;
    addr = $urandom & 32'hFFFF_FFFC;
    data = $urandom;
    strb = 4'($urandom);
    prot = 3'($urandom);
    exp_aw.push_back({addr, prot});
    exp_w.push_back({data, strb});
    exp_b.push_back(rule_resp(addr));
    if (!addr[6]) ref_mem[addr[5:2]] = merge(ref_mem[addr[5:2]], data, strb);
    @(negedge src_clk_i);
    {src_aw_valid_i, src_aw_addr_i, src_aw_prot_i} = {1'b1, addr, prot};
    {src_w_valid_i, src_w_data_i, src_w_strb_i} = {1'b1, data, strb};
    while (src_aw_valid_i || src_w_valid_i) begin
      #1;
      aw_done = src_aw_valid_i && src_aw_ready_o;
      w_done  = src_w_valid_i && src_w_ready_o;
      @(negedge src_clk_i);
      if (aw_done) src_aw_valid_i = 1'b0;
      if (w_done) src_w_valid_i = 1'b0;
    end
  endtask

  task automatic issue_read();
    logic [31:0] addr;
    logic [2:0] prot;
    bit done;
    addr = $urandom & 32'hFFFF_FFFC;
    prot = 3'($urandom);
    exp_ar.push_back({addr, prot});
    exp_r.push_back({ref_mem[addr[5:2]], rule_resp(addr)});
    @(negedge src_clk_i);
    {src_ar_valid_i, src_ar_addr_i, src_ar_prot_i} = {1'b1, addr, prot};
    done = 1'b0;
    while (!done) begin
      #1;
      done = src_ar_ready_o;
      @(negedge src_clk_i);
    end
    src_ar_valid_i = 1'b0;
  endtask

  task automatic report(string name, int errs);
    if (errs == 0) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", name, errs);
    end
  endtask

  initial begin
    int accepted;
    bit took;
    void'($urandom(62359));
    reset_i = 1'b1;
    {src_aw_valid_i, src_w_valid_i, src_ar_valid_i} = '0;
    {src_aw_addr_i, src_aw_prot_i, src_w_data_i, src_w_strb_i} = '0;
    {src_ar_addr_i, src_ar_prot_i} = '0;
    for (int i = 0; i < 16; i++) begin
      ref_mem[i]   = 32'h5A00_0000 | 32'(i * 32'h0101);
      slave_mem[i] = ref_mem[i];
    end

    // Reset for 2 source cycles with idle outputs checked during and after
    repeat (3) begin
      @(negedge src_clk_i);
      err_idle += mismatch("reset_idle", 36'd0, 36'({src_b_valid_o, src_r_valid_o,
                           dst_aw_valid_o, dst_w_valid_o, dst_ar_valid_o}));
      if (cycles >= 2) reset_i = 1'b0;
    end
    report("reset_idle", err_idle);

    repeat (40) issue_write();
    while (b_count < 40) @(negedge src_clk_i);
    if (exp_aw.size() != 0 || exp_w.size() != 0) begin
      $display("write_through: writes issued but never seen at the destination");
      err_wt++;
    end
    report("write_through", err_wt);
    report("write_resp", err_wr);

    repeat (40) issue_read();
    while (r_count < 40) @(negedge src_clk_i);
    report("read_back", err_rb);

    // Random readies on both sides
    bp_phase  = 1'b1;
    ready_pct = 40;
    repeat (30) issue_write();
    while (b_count < 70) @(negedge src_clk_i);
    repeat (30) issue_read();
    while (r_count < 70) @(negedge src_clk_i);
    repeat (10) @(negedge src_clk_i);
    if (b_count != 70 || r_count != 70 ||
        exp_aw.size() + exp_w.size() + exp_b.size() + exp_ar.size() + exp_r.size() != 0) begin
      $display("back_pressure: transfer counts differ from the issued ones");
      err_bp++;
    end
    report("back_pressure", err_bp);

    // Destination never takes AW, so the FIFO must fill and stay full
    ready_pct = 100;
    hold_aw   = 1'b1;
    accepted  = 0;
    @(negedge src_clk_i);
    src_aw_addr_i  = $urandom & 32'hFFFF_FFFC;
    src_aw_valid_i = 1'b1;
    repeat (30) begin
      #1;
      took = src_aw_ready_o;
      if (took) accepted++;
      @(negedge src_clk_i);
      if (took) src_aw_addr_i = $urandom & 32'hFFFF_FFFC;
    end
    err_full += mismatch("fifo_full", 36'(2 ** LogDepth), 36'(accepted));
    if (src_aw_ready_o) begin
      $display("fifo_full: source AW ready did not stay low");
      err_full++;
    end
    src_aw_valid_i = 1'b0;
    report("fifo_full", err_full);

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/axi_lite_cdc_pkg.sv
src/cdc_fifo_gray_src.sv
src/cdc_fifo_gray_dst.sv
src/axi_lite_cdc_src.sv
src/axi_lite_cdc_dst.sv
src/axi_lite_cdc.sv
tests/tb_axi_lite_cdc.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --top-module tb_axi_lite_cdc -f files.f -o sim_axi_lite_cdc \
  && ./obj_dir/sim_axi_lite_cdc > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
